// ==== filelist.f ====
rtl/mem_pkg.sv
rtl/sync_queue.sv
rtl/mem_client_arbiter.sv
rtl/dram_cmd_bridge.sv
rtl/dram_port_top.sv
verif/dram_model.sv
verif/tb_dram_port.sv

// ==== Makefile ====
# Verilator build and run of the DRAM command port testbench

TOP      ?= tb_dram_port
LOG      ?= sim.log
BUILD    ?= obj_dir
FILELIST ?= filelist.f
VFLAGS   ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	verilator $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verif/tb_dram_port.sv ====
`timescale 1ns/100ps

module tb_dram_port;

    import mem_pkg::*;

    // commands issued over all tests, sizes the timeout
    localparam int TOTAL_CMDS = 31;
    localparam int CYCLE_LIMIT = 20 * TOTAL_CMDS + 200;

    logic                   Mem_Clk;
    logic                   dram_reset;
    logic [N_CLIENTS-1:0]   client_cmd_valid;
    mem_cmd_t               client_cmd [N_CLIENTS];
    logic [N_CLIENTS-1:0]   client_cmd_ack;
    logic [N_CLIENTS-1:0]   client_rd_ack;
    logic [N_CLIENTS-1:0]   client_rd_valid;
    logic [DATA_W-1:0]      client_rd_data [N_CLIENTS];
    logic                   ready_level;
    logic                   dram_ready;
    logic                   dram_cmd_en;
    logic                   dram_rnw;
    logic [ADDR_W-1:0]      dram_address;
    logic [DATA_W-1:0]      dram_data_o;
    logic [BE_W-1:0]        dram_byte_enable;
    logic [DATA_W-1:0]      dram_data_i;
    logic                   dram_data_valid;
    int                     model_errors;

    int                     errors;
    int                     tests_run;
    int                     cycle_count = 0;
    integer                 seed;
    logic [DATA_W-1:0]      ref_mem [logic [ADDR_W-1:0]];
    logic [DATA_W-1:0]      expect0_q [$];
    logic [DATA_W-1:0]      expect1_q [$];
    client_id_t             accept_id_q [$];
    logic                   accept_rnw_q [$];

    dram_port_top dut0 (
        .Mem_Clk          (Mem_Clk),
        .dram_reset       (dram_reset),
        .client_cmd_valid (client_cmd_valid),
        .client_cmd       (client_cmd),
        .client_cmd_ack   (client_cmd_ack),
        .client_rd_ack    (client_rd_ack),
        .client_rd_valid  (client_rd_valid),
        .client_rd_data   (client_rd_data),
        .dram_ready       (dram_ready),
        .dram_cmd_en      (dram_cmd_en),
        .dram_rnw         (dram_rnw),
        .dram_address     (dram_address),
        .dram_data_o      (dram_data_o),
        .dram_byte_enable (dram_byte_enable),
        .dram_data_i      (dram_data_i),
        .dram_data_valid  (dram_data_valid)
    );

    dram_model model0 (
        .Mem_Clk          (Mem_Clk),
        .dram_reset       (dram_reset),
        .ready_level      (ready_level),
        .dram_ready       (dram_ready),
        .dram_cmd_en      (dram_cmd_en),
        .dram_rnw         (dram_rnw),
        .dram_address     (dram_address),
        .dram_data_o      (dram_data_o),
        .dram_byte_enable (dram_byte_enable),
        .dram_data_i      (dram_data_i),
        .dram_data_valid  (dram_data_valid),
        .error_count      (model_errors)
    );

    always #50 Mem_Clk = ~Mem_Clk;

    always @(posedge Mem_Clk)
    begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT)
        begin
            $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    // ----------------------------------------
    // reference memory and helpers
    // ----------------------------------------
    function automatic logic [DATA_W-1:0] addr_pattern(input logic [ADDR_W-1:0] a);
        return {a, a, a, a, a[15:0]};
    endfunction

    function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : addr_pattern(a);
    endfunction

    function automatic void ref_write(input mem_cmd_t cmd);
        logic [DATA_W-1:0] word;
        word = ref_read(cmd.addr);
        for (int b = 0; b < BE_W; b++)
        begin
            if (cmd.be[b])
            begin
                word[8*b +: 8] = cmd.data[8*b +: 8];
            end
        end
        ref_mem[cmd.addr] = word;
    endfunction

    function automatic mem_cmd_t make_cmd(input logic rnw, input logic [ADDR_W-1:0] addr,
        input logic [DATA_W-1:0] data, input logic [BE_W-1:0] be);
        mem_cmd_t cmd;
        cmd.data = data;
        cmd.be = be;
        cmd.addr = addr;
        cmd.rnw = rnw;
        return cmd;
    endfunction

    function automatic logic [DATA_W-1:0] rand_data();
        logic [159:0] bits;
        bits = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
        return bits[DATA_W-1:0];
    endfunction

    function automatic logic [BE_W-1:0] rand_be();
        logic [31:0] bits;
        bits = $random(seed);
        return bits[BE_W-1:0];
    endfunction

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
        input logic [DATA_W-1:0] actual);
        if (actual !== expected)
        begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // ----------------------------------------
    // client side monitor
    // ----------------------------------------
    task automatic note_accept(input int c, input mem_cmd_t cmd);
        accept_id_q.push_back(client_id_t'(c));
        accept_rnw_q.push_back(cmd.rnw);
        if (!cmd.rnw)
        begin
            ref_write(cmd);
        end
        else if (c == 0)
        begin
            expect0_q.push_back(ref_read(cmd.addr));
        end
        else
        begin
            expect1_q.push_back(ref_read(cmd.addr));
        end
    endtask

    task automatic take_beat(input int c, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] expected;
        if ((c == 0 && expect0_q.size() == 0) || (c == 1 && expect1_q.size() == 0))
        begin
            $display("client %0d got a read beat it never asked for at %0t", c, $time);
            errors++;
        end
        else
        begin
            if (c == 0)
            begin
                expected = expect0_q.pop_front();
            end
            else
            begin
                expected = expect1_q.pop_front();
            end
            check_value($sformatf("client_rd_data[%0d]", c), expected, data);
        end
    endtask

    // settled values just before the transfer edge
    always @(negedge Mem_Clk)
    begin
        #1;
        for (int c = 0; c < N_CLIENTS; c++)
        begin
            if (!dram_reset && client_cmd_valid[c] && client_cmd_ack[c])
            begin
                note_accept(c, client_cmd[c]);
            end
            if (client_rd_valid[c])
            begin
                take_beat(c, client_rd_data[c]);
            end
        end
    end

    task automatic drive_client(input int c, input mem_cmd_t cmds [$]);
        for (int k = 0; k < cmds.size(); k++)
        begin
            @(negedge Mem_Clk);
            client_cmd_valid[c] <= 1'b1;
            client_cmd[c] <= cmds[k];
            #1;
            while (!client_cmd_ack[c])
            begin
                @(negedge Mem_Clk);
                #1;
            end
        end
        @(negedge Mem_Clk);
        client_cmd_valid[c] <= 1'b0;
    endtask

    task automatic wait_returns();
        while (expect0_q.size() != 0 || expect1_q.size() != 0)
        begin
            @(negedge Mem_Clk);
        end
        // extra beats would show up here
        repeat (4) @(negedge Mem_Clk);
    endtask

    task automatic finish_test(input string name, input int start);
        tests_run++;
        $display("test %0d %s done, %0d errors", tests_run, name, errors + model_errors - start);
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic test_reset_read();
        int       start;
        mem_cmd_t cmds [$];
        start = errors + model_errors;
        for (int i = 0; i < 9; i++)
        begin
            @(negedge Mem_Clk);
            #1;
            check_value("dram_cmd_en", '0, DATA_W'(dram_cmd_en));
            check_value("client_rd_valid", '0, DATA_W'(client_rd_valid));
        end
        @(negedge Mem_Clk);
        dram_reset <= 1'b0;
        cmds.push_back(make_cmd(1'b1, 32'h0000_1000, '0, '0));
        drive_client(0, cmds);
        wait_returns();
        finish_test("reset_read", start);
    endtask

    task automatic test_write_readback();
        int       start;
        mem_cmd_t cmds [$];
        start = errors + model_errors;
        cmds.push_back(make_cmd(1'b0, 32'h0000_0100, rand_data(), rand_be()));
        cmds.push_back(make_cmd(1'b0, 32'h0000_0104, rand_data(), rand_be()));
        cmds.push_back(make_cmd(1'b1, 32'h0000_0100, '0, '0));
        cmds.push_back(make_cmd(1'b1, 32'h0000_0104, '0, '0));
        drive_client(1, cmds);
        wait_returns();
        finish_test("write_readback", start);
    endtask

    task automatic test_both_clients();
        int         start;
        int         first;
        client_id_t other;
        mem_cmd_t   c0 [$];
        mem_cmd_t   c1 [$];
        start = errors + model_errors;
        first = accept_id_q.size();
        for (int i = 0; i < 4; i++)
        begin
            c0.push_back(make_cmd(1'b1, 32'h0000_3000 + 4 * i, '0, '0));
            c1.push_back(make_cmd(1'b1, 32'h0000_0100 + 4 * i, '0, '0));
        end
        fork
            drive_client(0, c0);
            drive_client(1, c1);
        join
        wait_returns();
        for (int k = first + 1; k < accept_id_q.size(); k++)
        begin
            other = ~accept_id_q[k-1];
            check_value("accepted client id", DATA_W'(other), DATA_W'(accept_id_q[k]));
        end
        finish_test("both_clients", start);
    endtask

    task automatic test_pair_atomic();
        int       start;
        int       first;
        logic     found;
        mem_cmd_t c0 [$];
        mem_cmd_t c1 [$];
        start = errors + model_errors;
        first = accept_id_q.size();
        found = 1'b0;
        c0.push_back(make_cmd(1'b0, 32'h0000_2000, rand_data(), rand_be()));
        c0.push_back(make_cmd(1'b0, 32'h0000_2004, rand_data(), rand_be()));
        for (int i = 0; i < 4; i++)
        begin
            c1.push_back(make_cmd(1'b1, 32'h0000_5000 + 4 * i, '0, '0));
        end
        fork
            drive_client(1, c1);
            begin
                @(negedge Mem_Clk);
                drive_client(0, c0);
            end
        join
        wait_returns();
        // the command after the first half must be the second half
        for (int k = first; k < accept_id_q.size() - 1; k++)
        begin
            if (accept_id_q[k] == 1'b0 && !accept_rnw_q[k])
            begin
                check_value("client id after first write", '0, DATA_W'(accept_id_q[k+1]));
                check_value("rnw after first write", '0, DATA_W'(accept_rnw_q[k+1]));
                found = 1'b1;
                break;
            end
        end
        if (!found)
        begin
            $display("the write pair of client 0 was never accepted");
            errors++;
        end
        finish_test("pair_atomic", start);
    endtask

    task automatic test_backpressure();
        int       start;
        mem_cmd_t c0 [$];
        mem_cmd_t c1 [$];
        start = errors + model_errors;
        for (int i = 0; i < 6; i++)
        begin
            c0.push_back(make_cmd(1'b1, 32'h0000_2000 + 4 * i, '0, '0));
            c1.push_back(make_cmd(1'b1, 32'h0000_6000 + 4 * i, '0, '0));
        end
        ready_level <= 1'b0;
        client_rd_ack <= 2'b00;
        fork
            drive_client(0, c0);
            drive_client(1, c1);
            begin
                repeat (20)
                begin
                    @(negedge Mem_Clk);
                    #1;
                    check_value("dram_cmd_en", '0, DATA_W'(dram_cmd_en));
                end
                @(negedge Mem_Clk);
                ready_level <= 1'b1;
                repeat (20)
                begin
                    @(negedge Mem_Clk);
                    #1;
                    check_value("client_rd_valid", '0, DATA_W'(client_rd_valid));
                end
                @(negedge Mem_Clk);
                client_rd_ack <= 2'b11;
            end
        join
        wait_returns();
        finish_test("backpressure", start);
    endtask

    initial
    begin
        Mem_Clk = 1'b0;
        dram_reset = 1'b1;
        client_cmd_valid = '0;
        for (int c = 0; c < N_CLIENTS; c++)
        begin
            client_cmd[c] = '0;
        end
        client_rd_ack = '1;
        ready_level = 1'b1;
        errors = 0;
        tests_run = 0;
        seed = 32'he54b;

        test_reset_read();
        test_write_readback();
        test_both_clients();
        test_pair_atomic();
        test_backpressure();

        $display("tests run: %0d, errors: %0d", tests_run, errors + model_errors);
        if (errors + model_errors == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== verif/dram_model.sv ====
`timescale 1ns/100ps

module dram_model (
    input  logic                         Mem_Clk,
    input  logic                         dram_reset,
    input  logic                         ready_level,
    output logic                         dram_ready,
    input  logic                         dram_cmd_en,
    input  logic                         dram_rnw,
    input  logic [mem_pkg::ADDR_W-1:0]   dram_address,
    input  logic [mem_pkg::DATA_W-1:0]   dram_data_o,
    input  logic [mem_pkg::BE_W-1:0]     dram_byte_enable,
    output logic [mem_pkg::DATA_W-1:0]   dram_data_i,
    output logic                         dram_data_valid,
    output int                           error_count
);

    import mem_pkg::*;

    // cycles from read strobe to returned beat
    localparam int RD_DELAY = 6;

    logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
    logic [DATA_W-1:0] rd_data_q [$];
    int                rd_due_q [$];
    int                cycle;
    logic              beat2_due;

    assign dram_ready = ready_level;

    // untouched words read back as their own address
    function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
        return {a, a, a, a, a[15:0]};
    endfunction

    function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] a);
        return mem.exists(a) ? mem[a] : fill_word(a);
    endfunction

    task automatic write_beat();
        logic [DATA_W-1:0] word;
        word = read_word(dram_address);
        for (int b = 0; b < BE_W; b++)
        begin
            if (dram_byte_enable[b])
            begin
                word[8*b +: 8] = dram_data_o[8*b +: 8];
            end
        end
        mem[dram_address] = word;
    endtask

    initial
    begin
        dram_data_i = '0;
        dram_data_valid = 1'b0;
        error_count = 0;
        beat2_due = 1'b0;
        cycle = 0;
        forever
        begin
            @(negedge Mem_Clk);
            cycle++;
            if (rd_due_q.size() != 0 && rd_due_q[0] == cycle)
            begin
                dram_data_valid <= 1'b1;
                dram_data_i <= rd_data_q.pop_front();
                void'(rd_due_q.pop_front());
            end
            else
            begin
                dram_data_valid <= 1'b0;
            end
            // port outputs are settled for the coming rising edge
            #1;
            if (dram_reset)
            begin
                beat2_due = 1'b0;
                rd_data_q.delete();
                rd_due_q.delete();
            end
            else if (beat2_due)
            begin
                // a strobe here means the pair was split
                if (dram_cmd_en || dram_rnw)
                begin
                    $display("dram model: second write beat missing after strobe at %0t", $time);
                    error_count++;
                end
                else
                begin
                    write_beat();
                end
                beat2_due = 1'b0;
            end
            else if (dram_cmd_en && dram_rnw)
            begin
                rd_data_q.push_back(read_word(dram_address));
                rd_due_q.push_back(cycle + RD_DELAY);
            end
            else if (dram_cmd_en)
            begin
                write_beat();
                beat2_due = 1'b1;
            end
        end
    end

endmodule

// ==== rtl/dram_port_top.sv ====
`timescale 1ns/100ps

module dram_port_top (
    input  logic                                Mem_Clk,
    input  logic                                dram_reset,
    input  logic [mem_pkg::N_CLIENTS-1:0]       client_cmd_valid,
    input  mem_pkg::mem_cmd_t                   client_cmd [mem_pkg::N_CLIENTS],
    output logic [mem_pkg::N_CLIENTS-1:0]       client_cmd_ack,
    input  logic [mem_pkg::N_CLIENTS-1:0]       client_rd_ack,
    output logic [mem_pkg::N_CLIENTS-1:0]       client_rd_valid,
    output logic [mem_pkg::DATA_W-1:0]          client_rd_data [mem_pkg::N_CLIENTS],
    input  logic                                dram_ready,
    output logic                                dram_cmd_en,
    output logic                                dram_rnw,
    output logic [mem_pkg::ADDR_W-1:0]          dram_address,
    output logic [mem_pkg::DATA_W-1:0]          dram_data_o,
    output logic [mem_pkg::BE_W-1:0]            dram_byte_enable,
    input  logic [mem_pkg::DATA_W-1:0]          dram_data_i,
    input  logic                                dram_data_valid
);

    import mem_pkg::*;

    // arbiter to bridge
    logic               arb_cmd_valid;
    mem_cmd_t           arb_cmd;
    logic               cmd_space;
    logic               ret_avail;
    logic [DATA_W-1:0]  ret_data;
    logic               ret_pop;

    mem_client_arbiter arb0 (
        .Mem_Clk          (Mem_Clk),
        .dram_reset       (dram_reset),
        .client_cmd_valid (client_cmd_valid),
        .client_cmd       (client_cmd),
        .client_cmd_ack   (client_cmd_ack),
        .client_rd_ack    (client_rd_ack),
        .client_rd_valid  (client_rd_valid),
        .client_rd_data   (client_rd_data),
        .arb_cmd_valid    (arb_cmd_valid),
        .arb_cmd          (arb_cmd),
        .cmd_space        (cmd_space),
        .ret_avail        (ret_avail),
        .ret_data         (ret_data),
        .ret_pop          (ret_pop)
    );

    dram_cmd_bridge bridge0 (
        .Mem_Clk          (Mem_Clk),
        .dram_reset       (dram_reset),
        .arb_cmd_valid    (arb_cmd_valid),
        .arb_cmd          (arb_cmd),
        .cmd_space        (cmd_space),
        .ret_avail        (ret_avail),
        .ret_data         (ret_data),
        .ret_pop          (ret_pop),
        .dram_ready       (dram_ready),
        .dram_cmd_en      (dram_cmd_en),
        .dram_rnw         (dram_rnw),
        .dram_address     (dram_address),
        .dram_data_o      (dram_data_o),
        .dram_byte_enable (dram_byte_enable),
        .dram_data_i      (dram_data_i),
        .dram_data_valid  (dram_data_valid)
    );

endmodule

// ==== rtl/dram_cmd_bridge.sv ====
`timescale 1ns/100ps

module dram_cmd_bridge (
    input  logic                          Mem_Clk,
    input  logic                          dram_reset,
    input  logic                          arb_cmd_valid,
    input  mem_pkg::mem_cmd_t             arb_cmd,
    output logic                          cmd_space,
    output logic                          ret_avail,
    output logic [mem_pkg::DATA_W-1:0]    ret_data,
    input  logic                          ret_pop,
    input  logic                          dram_ready,
    output logic                          dram_cmd_en,
    output logic                          dram_rnw,
    output logic [mem_pkg::ADDR_W-1:0]    dram_address,
    output logic [mem_pkg::DATA_W-1:0]    dram_data_o,
    output logic [mem_pkg::BE_W-1:0]      dram_byte_enable,
    input  logic [mem_pkg::DATA_W-1:0]    dram_data_i,
    input  logic                          dram_data_valid
);

    import mem_pkg::*;

    mem_cmd_t              txn_head;
    logic                  txn_empty;
    logic [TXN_CNT_W-1:0]  txn_free;
    logic                  txn_pop;
    logic                  opn_head_rnw;
    logic                  opn_empty;
    logic [OPN_CNT_W-1:0]  opn_free;
    logic                  opn_push;
    logic                  rd_empty;
    logic                  write_toggle;
    logic [RD_CNT_W-1:0]   rd_credit;
    logic                  credit_ok;
    issue_state_t          issue_state;

    // ----------------------------------------
    // command side
    // ----------------------------------------

    // room for a whole write pair plus one operation
    assign cmd_space = (txn_free >= TXN_CNT_W'(2)) & (opn_free != '0);

    // set between the two beats of a write pair
    always_ff @(posedge Mem_Clk)
    begin
        if (dram_reset)
        begin
            write_toggle <= 1'b0;
        end
        else if (arb_cmd_valid)
        begin
            write_toggle <= arb_cmd.rnw ? 1'b0 : ~write_toggle;
        end
    end

    // one operation per read, and per completed write pair
    assign opn_push = arb_cmd_valid & (arb_cmd.rnw | write_toggle);

    sync_queue #(
        .WIDTH ($bits(mem_cmd_t)),
        .DEPTH (TXN_DEPTH)
    ) txn_queue (
        .Mem_Clk    (Mem_Clk),
        .dram_reset (dram_reset),
        .push       (arb_cmd_valid),
        .din        (arb_cmd),
        .pop        (txn_pop),
        .dout       (txn_head),
        .empty      (txn_empty),
        .free       (txn_free)
    );

    sync_queue #(
        .WIDTH (1),
        .DEPTH (OPN_DEPTH)
    ) opn_queue (
        .Mem_Clk    (Mem_Clk),
        .dram_reset (dram_reset),
        .push       (opn_push),
        .din        (arb_cmd.rnw),
        .pop        (dram_cmd_en),
        .dout       (opn_head_rnw),
        .empty      (opn_empty),
        .free       (opn_free)
    );

    // ----------------------------------------
    // issue sequencer
    // ----------------------------------------

    assign credit_ok = (rd_credit < RD_CNT_W'(RD_DEPTH));

    assign dram_cmd_en = (issue_state == ISSUE_IDLE) & dram_ready & ~opn_empty
        & ~txn_empty & (~opn_head_rnw | credit_ok);

    // second write beat leaves the cycle after the strobe
    assign txn_pop = dram_cmd_en | (issue_state == ISSUE_WR_BEAT2);

    assign dram_rnw = txn_head.rnw;
    assign dram_address = txn_head.addr;
    assign dram_data_o = txn_head.data;
    assign dram_byte_enable = txn_head.be;

    always_ff @(posedge Mem_Clk)
    begin
        if (dram_reset)
        begin
            issue_state <= ISSUE_IDLE;
        end
        else if (issue_state == ISSUE_WR_BEAT2)
        begin
            issue_state <= ISSUE_IDLE;
        end
        else if (dram_cmd_en && !opn_head_rnw)
        begin
            issue_state <= ISSUE_WR_BEAT2;
        end
    end

    // ----------------------------------------
    // read credits and returned data
    // ----------------------------------------

    // reads in flight plus beats waiting in the read data queue
    always_ff @(posedge Mem_Clk)
    begin
        if (dram_reset)
        begin
            rd_credit <= '0;
        end
        else if ((dram_cmd_en && opn_head_rnw) && !ret_pop)
        begin
            rd_credit <= rd_credit + 1'b1;
        end
        else if (!(dram_cmd_en && opn_head_rnw) && ret_pop && (rd_credit != '0))
        begin
            rd_credit <= rd_credit - 1'b1;
        end
    end

    sync_queue #(
        .WIDTH (DATA_W),
        .DEPTH (RD_DEPTH)
    ) rd_queue (
        .Mem_Clk    (Mem_Clk),
        .dram_reset (dram_reset),
        .push       (dram_data_valid),
        .din        (dram_data_i),
        .pop        (ret_pop),
        .dout       (ret_data),
        .empty      (rd_empty),
        .free       ()
    );

    // a beat is offered only when the queue still holds it
    assign ret_avail = ~rd_empty;

endmodule

// ==== rtl/mem_client_arbiter.sv ====
`timescale 1ns/100ps

module mem_client_arbiter (
    input  logic                                     Mem_Clk,
    input  logic                                     dram_reset,
    input  logic [mem_pkg::N_CLIENTS-1:0]            client_cmd_valid,
    input  mem_pkg::mem_cmd_t                        client_cmd [mem_pkg::N_CLIENTS],
    output logic [mem_pkg::N_CLIENTS-1:0]            client_cmd_ack,
    input  logic [mem_pkg::N_CLIENTS-1:0]            client_rd_ack,
    output logic [mem_pkg::N_CLIENTS-1:0]            client_rd_valid,
    output logic [mem_pkg::DATA_W-1:0]               client_rd_data [mem_pkg::N_CLIENTS],
    output logic                                     arb_cmd_valid,
    output mem_pkg::mem_cmd_t                        arb_cmd,
    input  logic                                     cmd_space,
    input  logic                                     ret_avail,
    input  logic [mem_pkg::DATA_W-1:0]               ret_data,
    output logic                                     ret_pop
);

    import mem_pkg::*;

    client_id_t            last_grant;
    client_id_t            gnt;
    logic                  pair_lock;
    logic                  accept_ok;
    client_id_t            owner_head;
    logic                  owner_empty;
    logic [RD_CNT_W-1:0]   owner_free;

    // ----------------------------------------
    // grant selection
    // ----------------------------------------

    // a locked pair stays with the client served last
    always_comb
    begin
        if (pair_lock)
        begin
            gnt = last_grant;
        end
        else if (client_cmd_valid[~last_grant])
        begin
            gnt = ~last_grant;
        end
        else if (client_cmd_valid[last_grant])
        begin
            gnt = last_grant;
        end
        else
        begin
            gnt = ~last_grant;
        end
    end

    // reads also need a slot in the owner queue
    assign accept_ok = cmd_space & (~client_cmd[gnt].rnw | (owner_free != '0));

    always_comb
    begin
        client_cmd_ack = '0;
        client_cmd_ack[gnt] = accept_ok;
    end

    assign arb_cmd_valid = accept_ok & client_cmd_valid[gnt];
    assign arb_cmd = client_cmd[gnt];

    always_ff @(posedge Mem_Clk)
    begin
        if (dram_reset)
        begin
            last_grant <= '0;
            pair_lock <= 1'b0;
        end
        else if (arb_cmd_valid)
        begin
            last_grant <= gnt;
            // first write of a pair locks, the next command unlocks
            if (pair_lock)
            begin
                pair_lock <= 1'b0;
            end
            else if (!arb_cmd.rnw)
            begin
                pair_lock <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // read return routing
    // ----------------------------------------

    sync_queue #(
        .WIDTH ($bits(client_id_t)),
        .DEPTH (RD_DEPTH)
    ) owner_queue (
        .Mem_Clk    (Mem_Clk),
        .dram_reset (dram_reset),
        .push       (arb_cmd_valid & arb_cmd.rnw),
        .din        (gnt),
        .pop        (ret_pop),
        .dout       (owner_head),
        .empty      (owner_empty),
        .free       (owner_free)
    );

    always_comb
    begin
        for (int i = 0; i < N_CLIENTS; i++)
        begin
            client_rd_valid[i] = ret_avail & ~owner_empty & (owner_head == client_id_t'(i))
                & client_rd_ack[i];
            client_rd_data[i] = ret_data;
        end
    end

    // only the owner of the head beat can take it
    assign ret_pop = |client_rd_valid;

endmodule

// ==== rtl/sync_queue.sv ====
`timescale 1ns/100ps

module sync_queue #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic                         Mem_Clk,
    input  logic                         dram_reset,
    input  logic                         push,
    input  logic [WIDTH-1:0]             din,
    input  logic                         pop,
    output logic [WIDTH-1:0]             dout,
    output logic                         empty,
    output logic [$clog2(DEPTH+1)-1:0]   free
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign empty = (count == '0);
    assign full = (count == CNT_W'(DEPTH));
    assign free = CNT_W'(DEPTH) - count;

    // requests that cannot be served are dropped
    assign do_push = push & ~full;
    assign do_pop = pop & ~empty;

    // first word falls through
    assign dout = mem[rd_ptr];

    always_ff @(posedge Mem_Clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge Mem_Clk)
    begin
        if (dram_reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leave the count alone
            if (do_push && !do_pop)
            begin
                count <= count + 1'b1;
            end
            else if (do_pop && !do_push)
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== rtl/mem_pkg.sv ====
package mem_pkg;

    // ----------------------------------------
    // widths of the DRAM command port
    // ----------------------------------------
    localparam int DATA_W = 144;
    localparam int BE_W = 18;
    localparam int ADDR_W = 32;

    // peer clients behind the arbiter
    localparam int N_CLIENTS = 2;

    // ----------------------------------------
    // queue depths and count widths
    // ----------------------------------------
    localparam int TXN_DEPTH = 16;
    localparam int OPN_DEPTH = 8;
    localparam int RD_DEPTH = 8;

    // free counts run from 0 up to the full depth
    localparam int TXN_CNT_W = $clog2(TXN_DEPTH + 1);
    localparam int OPN_CNT_W = $clog2(OPN_DEPTH + 1);
    localparam int RD_CNT_W = $clog2(RD_DEPTH + 1);

    // one command beat, same field order as the transaction queue entry
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [BE_W-1:0]   be;
        logic [ADDR_W-1:0] addr;
        logic              rnw;
    } mem_cmd_t;

    typedef logic [$clog2(N_CLIENTS)-1:0] client_id_t;

    // issue sequencer of the bridge
    typedef enum logic {
        ISSUE_IDLE,
        ISSUE_WR_BEAT2
    } issue_state_t;

endpackage
